//--- core_pkg.sv
package core_pkg;

    localparam int xlen       = 64;
    localparam int reg_addr_w = 5;
    localparam int ram_words  = 16;
    localparam int ram_addr_w = 4;

    // major opcodes of the supported subset
    localparam logic [6:0] op_imm   = 7'b0010011;
    localparam logic [6:0] op_reg   = 7'b0110011;
    localparam logic [6:0] op_lui   = 7'b0110111;
    localparam logic [6:0] op_load  = 7'b0000011;
    localparam logic [6:0] op_store = 7'b0100011;

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;
    typedef logic [31:0]           insn_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_lui,
        alu_ld,
        alu_sd,
        alu_bad
    } alu_op_e;

    // decode -> execute
    typedef struct packed {
        logic      valid;
        alu_op_e   op;
        reg_addr_t rd;
        logic      writes_rd;
        word_t     rs1_val;
        word_t     rs2_val;
        word_t     imm;       // already sign-extended
        logic      use_imm;
    } dec_pkt_t;

    // execute -> result
    typedef struct packed {
        logic      valid;
        alu_op_e   op;
        reg_addr_t rd;
        logic      writes_rd;
        word_t     result;     // alu value or memory address
        word_t     store_data;
    } exe_pkt_t;

    typedef struct packed {
        logic      valid;
        logic      illegal;
        reg_addr_t rd;
        word_t     data;
    } retire_t;

    typedef enum logic {
        res_idle,
        res_load_wait
    } rd_state_e;

endpackage

//--- design/execute_unit.sv
`timescale 1ns/10ps

module execute_unit (
    input  logic               clk,
    input  logic               rst_n,
    input  core_pkg::dec_pkt_t dec_pkt,
    output logic               exe_ready,
    output core_pkg::exe_pkt_t exe_pkt,
    input  logic               res_ready
);
    import core_pkg::*;

    word_t      op_a;
    word_t      op_b;
    logic [5:0] shamt;
    word_t      alu_out;
    exe_pkt_t   exe_d;
    exe_pkt_t   exe_q;       // execute register payload
    logic       exe_valid;

    assign op_a  = dec_pkt.rs1_val;
    assign op_b  = dec_pkt.use_imm ? dec_pkt.imm : dec_pkt.rs2_val;
    assign shamt = op_b[5:0];

    always_comb begin
        case (dec_pkt.op)
            alu_add: alu_out = op_a + op_b;
            alu_ld:  alu_out = op_a + op_b;   // address
            alu_sd:  alu_out = op_a + op_b;
            alu_sub: alu_out = op_a - op_b;
            alu_and: alu_out = op_a & op_b;
            alu_or:  alu_out = op_a | op_b;
            alu_xor: alu_out = op_a ^ op_b;
            alu_sll: alu_out = op_a << shamt;
            alu_srl: alu_out = op_a >> shamt;
            alu_lui: alu_out = dec_pkt.imm;
            default: alu_out = '0;
        endcase
    end

    always_comb begin
        exe_d.valid      = dec_pkt.valid;
        exe_d.op         = dec_pkt.op;
        exe_d.rd         = dec_pkt.rd;
        exe_d.writes_rd  = dec_pkt.writes_rd;
        exe_d.result     = alu_out;
        exe_d.store_data = dec_pkt.rs2_val;
    end

    // only blocked when full and result is holding
    assign exe_ready = !exe_valid | res_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exe_valid <= 1'b0;
        end else if (exe_ready) begin
            exe_valid <= dec_pkt.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (exe_ready && dec_pkt.valid) begin
            exe_q <= exe_d;
        end
    end

    always_comb begin
        exe_pkt       = exe_q;
        exe_pkt.valid = exe_valid;
    end

endmodule

//--- design/hazard_unit.sv
`timescale 1ns/10ps

module hazard_unit (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                dec_valid,
    input  core_pkg::reg_addr_t dec_rs1,
    input  core_pkg::reg_addr_t dec_rs2,
    input  logic                dec_uses_rs1,
    input  logic                dec_uses_rs2,
    input  core_pkg::reg_addr_t dec_rd,
    input  logic                dec_writes_rd,
    input  logic                issue,
    input  logic                wb_en,
    input  core_pkg::reg_addr_t wb_rd,
    output logic                stall
);
    import core_pkg::*;

    logic [(1 << reg_addr_w)-1:0] busy;       // one bit per register, set while a write is pending
    logic [(1 << reg_addr_w)-1:0] busy_next;
    logic                         wait_rs1;
    logic                         wait_rs2;
    logic                         wait_rd;

    // a register written back this cycle is already visible through the file
    assign wait_rs1 = dec_uses_rs1 & busy[dec_rs1] & !(wb_en && wb_rd == dec_rs1);
    assign wait_rs2 = dec_uses_rs2 & busy[dec_rs2] & !(wb_en && wb_rd == dec_rs2);

    // second writer to the same rd waits too, so a single busy bit never loses track
    assign wait_rd  = dec_writes_rd & busy[dec_rd] & !(wb_en && wb_rd == dec_rd);

    assign stall = dec_valid & (wait_rs1 | wait_rs2 | wait_rd);

    always_comb begin
        busy_next = busy;
        if (wb_en) begin
            busy_next[wb_rd] = 1'b0;
        end
        if (issue && dec_writes_rd && dec_rd != '0) begin
            busy_next[dec_rd] = 1'b1;   // set wins over a same-cycle clear
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= '0;
        end else begin
            busy <= busy_next;
        end
    end

endmodule

//--- design/insn_decode.sv
`timescale 1ns/10ps

module insn_decode (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  core_pkg::insn_t     wb_dat_i,
    output logic                wb_ack,
    input  logic                stall,
    input  logic                exe_ready,
    output core_pkg::reg_addr_t rs1_addr,
    output core_pkg::reg_addr_t rs2_addr,
    input  core_pkg::word_t     rs1_data,
    input  core_pkg::word_t     rs2_data,
    output logic                dec_valid,
    output core_pkg::reg_addr_t dec_rs1,
    output core_pkg::reg_addr_t dec_rs2,
    output logic                dec_uses_rs1,
    output logic                dec_uses_rs2,
    output core_pkg::reg_addr_t dec_rd,
    output logic                dec_writes_rd,
    output logic                issue,
    output core_pkg::dec_pkt_t  dec_pkt
);
    import core_pkg::*;

    insn_t      ir;          // decode register
    logic       ir_valid;
    logic       take;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    alu_op_e    op;
    word_t      imm;
    logic       use_imm;
    logic       uses_rs1;
    logic       uses_rs2;
    logic       writes_rd;

    // slot is free when empty or when the held word leaves this cycle
    assign take   = wb_cyc & wb_stb & wb_we & (!ir_valid | issue);
    assign wb_ack = wb_cyc & wb_stb & (!wb_we | !ir_valid | issue); // reads just acked

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ir_valid <= 1'b0;
        end else if (take) begin
            ir_valid <= 1'b1;
        end else if (issue) begin
            ir_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            ir <= wb_dat_i;
        end
    end

    assign opcode = ir[6:0];
    assign funct3 = ir[14:12];
    assign funct7 = ir[31:25];

    always_comb begin
        op        = alu_bad;
        imm       = '0;
        use_imm   = 1'b0;
        uses_rs1  = 1'b0;
        uses_rs2  = 1'b0;
        writes_rd = 1'b0;
        case (opcode)
            op_imm: begin
                imm       = {{(xlen-12){ir[31]}}, ir[31:20]};
                use_imm   = 1'b1;
                uses_rs1  = 1'b1;
                writes_rd = 1'b1;
                if (funct3 == 3'b000) begin
                    op = alu_add;
                end else if (funct3 == 3'b001 && ir[31:26] == 6'd0) begin
                    op = alu_sll;   // rv64 shamt is 6 bits
                end else if (funct3 == 3'b101 && ir[31:26] == 6'd0) begin
                    op = alu_srl;
                end
            end
            op_reg: begin
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
                writes_rd = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: op = alu_add;
                    {7'b0100000, 3'b000}: op = alu_sub;
                    {7'b0000000, 3'b100}: op = alu_xor;
                    {7'b0000000, 3'b110}: op = alu_or;
                    {7'b0000000, 3'b111}: op = alu_and;
                    default:              op = alu_bad;
                endcase
            end
            op_lui: begin
                op        = alu_lui;
                imm       = {{(xlen-32){ir[31]}}, ir[31:12], 12'b0};
                writes_rd = 1'b1;
            end
            op_load: begin
                imm       = {{(xlen-12){ir[31]}}, ir[31:20]};
                use_imm   = 1'b1;
                uses_rs1  = 1'b1;
                writes_rd = 1'b1;
                if (funct3 == 3'b011) begin
                    op = alu_ld;
                end
            end
            op_store: begin
                imm      = {{(xlen-12){ir[31]}}, ir[31:25], ir[11:7]};
                use_imm  = 1'b1;
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                if (funct3 == 3'b011) begin
                    op = alu_sd;
                end
            end
            default: op = alu_bad;
        endcase
        // anything unrecognised touches no register
        if (op == alu_bad) begin
            use_imm   = 1'b0;
            uses_rs1  = 1'b0;
            uses_rs2  = 1'b0;
            writes_rd = 1'b0;
        end
    end

    assign rs1_addr      = ir[19:15];
    assign rs2_addr      = ir[24:20];
    assign dec_valid     = ir_valid;
    assign dec_rs1       = rs1_addr;
    assign dec_rs2       = rs2_addr;
    assign dec_uses_rs1  = uses_rs1;
    assign dec_uses_rs2  = uses_rs2;
    assign dec_rd        = ir[11:7];
    assign dec_writes_rd = writes_rd;
    assign issue         = ir_valid & !stall & exe_ready;

    always_comb begin
        dec_pkt.valid     = issue;
        dec_pkt.op        = op;
        dec_pkt.rd        = dec_rd;
        dec_pkt.writes_rd = writes_rd;
        dec_pkt.rs1_val   = rs1_data;
        dec_pkt.rs2_val   = rs2_data;
        dec_pkt.imm       = imm;
        dec_pkt.use_imm   = use_imm;
    end

endmodule

//--- design/reg_file.sv
`timescale 1ns/10ps

module reg_file (
    input  logic                clk,
    input  logic                rst_n,
    input  core_pkg::reg_addr_t rs1_addr,
    input  core_pkg::reg_addr_t rs2_addr,
    output core_pkg::word_t     rs1_data,
    output core_pkg::word_t     rs2_data,
    input  logic                wb_en,
    input  core_pkg::reg_addr_t wb_rd,
    input  core_pkg::word_t     wb_data
);
    import core_pkg::*;

    word_t regs [1 << reg_addr_w];
    logic  wr_en;

    // x0 is never written, so regs[0] stays at its reset zero
    assign wr_en = wb_en && wb_rd != '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < (1 << reg_addr_w); i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // write-through so decode sees a value in the cycle it lands
    assign rs1_data = (wr_en && wb_rd == rs1_addr) ? wb_data : regs[rs1_addr];
    assign rs2_data = (wr_en && wb_rd == rs2_addr) ? wb_data : regs[rs2_addr];

endmodule

//--- design/result_unit.sv
`timescale 1ns/10ps

module result_unit (
    input  logic                clk,
    input  logic                rst_n,
    input  core_pkg::exe_pkt_t  exe_pkt,
    output logic                res_ready,
    output logic                wb_en,
    output core_pkg::reg_addr_t wb_rd,
    output core_pkg::word_t     wb_data,
    output core_pkg::retire_t   retire
);
    import core_pkg::*;

    word_t                 ram [ram_words];   // data memory, doubleword entries
    exe_pkt_t              res_q;
    logic                  res_valid;
    rd_state_e             state;
    word_t                 ld_q;              // ram read data
    logic [ram_addr_w-1:0] ram_idx;
    logic                  is_load;
    logic                  fire;

    assign ram_idx = res_q.result[3 +: ram_addr_w];   // doubleword index mod 16
    assign is_load = res_valid && res_q.op == alu_ld;

    // a load holds the stage for its ram read cycle
    assign res_ready = !(is_load && state == res_idle);
    assign fire      = res_valid && (!is_load || state == res_load_wait);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
            state     <= res_idle;
        end else begin
            if (res_ready) begin
                res_valid <= exe_pkt.valid;
            end
            case (state)
                res_idle:      if (is_load) state <= res_load_wait;
                res_load_wait: state <= res_idle;
                default:       state <= res_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (res_ready && exe_pkt.valid) begin
            res_q <= exe_pkt;
        end
        if (is_load && state == res_idle) begin
            ld_q <= ram[ram_idx];
        end
        if (fire && res_q.op == alu_sd) begin
            ram[ram_idx] <= res_q.store_data;
        end
    end

    assign wb_en   = fire && res_q.writes_rd;
    assign wb_rd   = res_q.rd;
    assign wb_data = is_load ? ld_q : res_q.result;

    // stores report their address, illegal ops report no rd
    always_comb begin
        retire.valid   = fire;
        retire.illegal = res_q.op == alu_bad;
        retire.rd      = res_q.writes_rd ? res_q.rd : '0;
        retire.data    = wb_data;
    end

endmodule

//--- design/seed_core.sv
`timescale 1ns/10ps

module seed_core (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              wb_cyc,
    input  logic              wb_stb,
    input  logic              wb_we,
    input  core_pkg::insn_t   wb_dat_i,
    output logic              wb_ack,
    output core_pkg::retire_t retire
);
    import core_pkg::*;

    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;
    logic      dec_valid;
    reg_addr_t dec_rs1;
    reg_addr_t dec_rs2;
    logic      dec_uses_rs1;
    logic      dec_uses_rs2;
    reg_addr_t dec_rd;
    logic      dec_writes_rd;
    logic      issue;
    logic      stall;
    dec_pkt_t  dec_pkt;
    logic      exe_ready;
    exe_pkt_t  exe_pkt;
    logic      res_ready;
    logic      wb_en;       // register write-back, not the bus
    reg_addr_t wb_rd;
    word_t     wb_data;

    insn_decode decode_i (
        .clk, .rst_n, .wb_cyc, .wb_stb, .wb_we, .wb_dat_i, .wb_ack, .stall, .exe_ready,
        .rs1_addr, .rs2_addr, .rs1_data, .rs2_data, .dec_valid, .dec_rs1, .dec_rs2,
        .dec_uses_rs1, .dec_uses_rs2, .dec_rd, .dec_writes_rd, .issue, .dec_pkt
    );

    hazard_unit hazard_i (
        .clk, .rst_n, .dec_valid, .dec_rs1, .dec_rs2, .dec_uses_rs1, .dec_uses_rs2,
        .dec_rd, .dec_writes_rd, .issue, .wb_en, .wb_rd, .stall
    );

    reg_file regs_i (
        .clk, .rst_n, .rs1_addr, .rs2_addr, .rs1_data, .rs2_data, .wb_en, .wb_rd, .wb_data
    );

    execute_unit execute_i (
        .clk, .rst_n, .dec_pkt, .exe_ready, .exe_pkt, .res_ready
    );

    result_unit result_i (
        .clk, .rst_n, .exe_pkt, .res_ready, .wb_en, .wb_rd, .wb_data, .retire
    );

endmodule

//--- seed_core.f
core_pkg.sv
design/insn_decode.sv
design/hazard_unit.sv
design/reg_file.sv
design/execute_unit.sv
design/result_unit.sv
design/seed_core.sv
tests/seed_core_tb.sv

//--- tests/seed_core_tb.sv
`timescale 1ns/10ps

module seed_core_tb;
    import core_pkg::*;

    localparam int n_tests    = 23;
    localparam int timeout_cy = n_tests * 12 + 50;

    // one program step with the retire record it should produce
    typedef struct packed {
        insn_t     insn;
        logic      illegal;
        reg_addr_t rd;
        word_t     data;
    } entry_t;

    logic    clk;
    logic    rst_n;
    logic    wb_cyc;
    logic    wb_stb;
    logic    wb_we;
    insn_t   wb_dat_i;
    logic    wb_ack;
    retire_t retire;

    entry_t  tbl [n_tests];
    int      n_entries;
    integer  seed;
    int      n_retired;
    int      n_acked;
    int      n_pass;
    int      n_fail;

    seed_core dut_i (
        .clk, .rst_n, .wb_cyc, .wb_stb, .wb_we, .wb_dat_i, .wb_ack, .retire
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic insn_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                    input logic [2:0] f3, input reg_addr_t rd,
                                    input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic insn_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3,
                                    input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, op_reg};
    endfunction

    function automatic insn_t enc_sd(input logic [11:0] imm, input reg_addr_t rs2,
                                     input reg_addr_t rs1);
        return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], op_store};
    endfunction

    task automatic add_entry(input insn_t insn, input logic illegal, input reg_addr_t rd,
                             input word_t data);
        tbl[n_entries] = {insn, illegal, rd, data};
        n_entries++;
    endtask

    task automatic fill_table();
        // independent alu ops
        add_entry(enc_i(12'd100, 5'd0, 3'b000, 5'd1, op_imm), 1'b0, 5'd1, 64'h64);
        add_entry(enc_i(12'hffd, 5'd0, 3'b000, 5'd2, op_imm), 1'b0, 5'd2, 64'hffff_ffff_ffff_fffd);
        add_entry({20'h12345, 5'd3, op_lui}, 1'b0, 5'd3, 64'h1234_5000);
        add_entry(enc_r(7'h00, 5'd3, 5'd1, 3'b000, 5'd4), 1'b0, 5'd4, 64'h1234_5064);
        add_entry(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd6), 1'b0, 5'd6, 64'h67);
        add_entry(enc_r(7'h00, 5'd2, 5'd3, 3'b111, 5'd7), 1'b0, 5'd7, 64'h1234_5000);
        add_entry(enc_r(7'h00, 5'd3, 5'd1, 3'b110, 5'd8), 1'b0, 5'd8, 64'h1234_5064);
        add_entry(enc_r(7'h00, 5'd1, 5'd2, 3'b100, 5'd9), 1'b0, 5'd9, 64'hffff_ffff_ffff_ff99);
        add_entry(enc_i(12'd40, 5'd1, 3'b001, 5'd10, op_imm), 1'b0, 5'd10, 64'h6400_0000_0000);
        add_entry(enc_i(12'd60, 5'd2, 3'b101, 5'd11, op_imm), 1'b0, 5'd11, 64'hf);
        // raw chain on x5
        add_entry(enc_i(12'd1, 5'd0, 3'b000, 5'd5, op_imm), 1'b0, 5'd5, 64'h1);
        add_entry(enc_i(12'd2, 5'd5, 3'b000, 5'd5, op_imm), 1'b0, 5'd5, 64'h3);
        add_entry(enc_i(12'd4, 5'd5, 3'b000, 5'd5, op_imm), 1'b0, 5'd5, 64'h7);
        add_entry(enc_i(12'd8, 5'd5, 3'b000, 5'd5, op_imm), 1'b0, 5'd5, 64'hf);
        // store, load back, then use the loaded value
        add_entry(enc_sd(12'd16, 5'd4, 5'd0), 1'b0, 5'd0, 64'h10);
        add_entry(enc_i(12'd16, 5'd0, 3'b011, 5'd12, op_load), 1'b0, 5'd12, 64'h1234_5064);
        add_entry(enc_r(7'h00, 5'd1, 5'd12, 3'b000, 5'd13), 1'b0, 5'd13, 64'h1234_50c8);
        // x0 write is dropped
        add_entry(enc_i(12'd5, 5'd1, 3'b000, 5'd0, op_imm), 1'b0, 5'd0, 64'h69);
        add_entry(enc_r(7'h00, 5'd5, 5'd0, 3'b000, 5'd14), 1'b0, 5'd14, 64'hf);
        // unknown opcode naming x1, then mul naming x6
        add_entry(enc_i(12'h000, 5'd2, 3'b000, 5'd1, 7'h7f), 1'b1, 5'd0, 64'h0);
        add_entry(enc_r(7'h01, 5'd2, 5'd1, 3'b000, 5'd6), 1'b1, 5'd0, 64'h0);
        add_entry(enc_i(12'd0, 5'd1, 3'b000, 5'd15, op_imm), 1'b0, 5'd15, 64'h64);
        add_entry(enc_r(7'h00, 5'd0, 5'd6, 3'b000, 5'd16), 1'b0, 5'd16, 64'h67);
    endtask

    // called just after a rising edge, returns just after the capturing edge
    task automatic bus_write(input insn_t word);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_dat_i = word;
        @(negedge clk);
        while (!wb_ack) @(negedge clk);
        @(posedge clk);
        #5;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #5;
        end
    endtask

    // retire records and acks, sampled mid-cycle
    always @(negedge clk) begin : check_retire
        entry_t want;
        logic   ok;
        if (wb_ack) n_acked++;
        if (retire.valid) begin
            if (n_retired >= n_tests) begin
                $display("unexpected retire record after the last table entry");
                n_fail++;
            end else begin
                want = tbl[n_retired];
                ok   = 1'b1;
                if (retire.illegal !== want.illegal) begin
                    $display("mismatch retire.illegal test %0d: got %h expected %h",
                             n_retired, retire.illegal, want.illegal);
                    ok = 1'b0;
                end
                if (retire.rd !== want.rd) begin
                    $display("mismatch retire.rd test %0d: got %h expected %h",
                             n_retired, retire.rd, want.rd);
                    ok = 1'b0;
                end
                if (retire.data !== want.data) begin
                    $display("mismatch retire.data test %0d: got %h expected %h",
                             n_retired, retire.data, want.data);
                    ok = 1'b0;
                end
                if (ok) n_pass++;
                else n_fail++;
                $display("test %0d insn %h %s", n_retired, want.insn, ok ? "ok" : "failed");
            end
            n_retired++;
        end
    end

    initial begin : run
        int gap;
        rst_n     = 1'b0;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_dat_i  = '0;
        seed      = 32'h5f65_cd83;
        n_entries = 0;
        n_retired = 0;
        n_acked   = 0;
        n_pass    = 0;
        n_fail    = 0;
        fill_table();
        repeat (2) @(posedge clk);
        #5 rst_n = 1'b1;
        for (int i = 0; i < n_tests; i++) begin
            bus_write(tbl[i].insn);
            gap = $unsigned($random(seed)) % 3;
            idle_cycles(gap);
        end
        while (n_retired < n_tests) @(posedge clk);
        repeat (6) @(posedge clk);   // room for stray records
        if (n_acked != n_tests) begin
            $display("bus acked %0d times for %0d writes", n_acked, n_tests);
        end
        $display("passed %0d failed %0d acks %0d retired %0d",
                 n_pass, n_fail, n_acked, n_retired);
        if (n_fail == 0 && n_acked == n_tests && n_retired == n_tests) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (timeout_cy) @(posedge clk);
        $display("timed out after %0d cycles with %0d of %0d records retired",
                 timeout_cy, n_retired, n_tests);
        $display("TEST FAIL");
        $finish;
    end

endmodule
